// File: riscv_pkg.sv
package riscv_pkg;

  // register width of the RV32I base ISA
  localparam int XLEN = 32;

  // data, address and instruction values
  typedef logic [XLEN-1:0] word_t;

  // register index, x0 to x31
  typedef logic [4:0] reg_idx_t;

  // major opcode, insn[6:0]
  typedef logic [6:0] opcode_t;

  // one bit per byte lane of a data word
  typedef logic [3:0] strobe_t;

  // major opcodes
  localparam opcode_t OP_LOAD     = 7'b00_000_11;
  localparam opcode_t OP_STORE    = 7'b01_000_11;
  localparam opcode_t OP_BRANCH   = 7'b11_000_11;
  localparam opcode_t OP_JALR     = 7'b11_001_11;
  localparam opcode_t OP_JAL      = 7'b11_011_11;
  localparam opcode_t OP_MISC_MEM = 7'b00_011_11;
  localparam opcode_t OP_IMM      = 7'b00_100_11;
  localparam opcode_t OP_REG      = 7'b01_100_11;
  localparam opcode_t OP_SYSTEM   = 7'b11_100_11;
  localparam opcode_t OP_AUIPC    = 7'b00_101_11;
  localparam opcode_t OP_LUI      = 7'b01_101_11;

  // ALU operation
  // pass_b forwards the second operand, used by LUI
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // branch condition, none for every non-branch instruction
  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU
  } br_cond_e;

  // access size of loads and stores, encoded as funct3[1:0]
  typedef enum logic [1:0] {
    MEM_BYTE = 2'b00,
    MEM_HALF = 2'b01,
    MEM_WORD = 2'b10
  } mem_size_e;

endpackage

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic               clk,
  input  logic               rst,
  input  riscv_pkg::reg_idx_t rs1_i,
  input  riscv_pkg::reg_idx_t rs2_i,
  output riscv_pkg::word_t   rs1_data_o,
  output riscv_pkg::word_t   rs2_data_o,
  input  riscv_pkg::reg_idx_t rd_i,
  input  riscv_pkg::word_t   rd_data_i,
  input  logic               we_i
);

  localparam int NUM_REGS = 32;

  riscv_pkg::word_t regs [NUM_REGS];

  // two asynchronous read ports
  assign rs1_data_o = regs[rs1_i];
  assign rs2_data_o = regs[rs2_i];

  // x0 is cleared by reset and never written, so it always reads zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (rd_i != 5'd0)) begin
      regs[rd_i] <= rd_data_i;
    end
  end

endmodule

// File: insn_decode.sv
`timescale 1ns/1ps

module insn_decode (
  input  riscv_pkg::word_t     insn_i,
  output riscv_pkg::reg_idx_t  rs1_o,
  output riscv_pkg::reg_idx_t  rs2_o,
  output riscv_pkg::reg_idx_t  rd_o,
  output riscv_pkg::word_t     imm_o,
  output riscv_pkg::alu_op_e   alu_op_o,
  output logic                 alu_src_imm_o,
  output riscv_pkg::br_cond_e  br_cond_o,
  output logic                 jal_o,
  output logic                 jalr_o,
  output logic                 auipc_o,
  output logic                 load_o,
  output logic                 store_o,
  output riscv_pkg::mem_size_e mem_size_o,
  output logic                 mem_unsigned_o,
  output logic                 reg_write_o,
  output logic                 halt_req_o,
  output logic                 illegal_o
);

  riscv_pkg::opcode_t opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  riscv_pkg::word_t   imm_i;
  riscv_pkg::word_t   imm_s;
  riscv_pkg::word_t   imm_b;
  riscv_pkg::word_t   imm_j;
  riscv_pkg::word_t   imm_u;
  riscv_pkg::alu_op_e arith_op;
  logic               funct7_ok;

  assign opcode = insn_i[6:0];
  assign funct3 = insn_i[14:12];
  assign funct7 = insn_i[31:25];
  assign rd_o   = insn_i[11:7];
  assign rs1_o  = insn_i[19:15];
  assign rs2_o  = insn_i[24:20];

  // immediates, all sign-extended from insn[31]
  assign imm_i = {{20{insn_i[31]}}, insn_i[31:20]};
  assign imm_s = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
  assign imm_b = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};
  assign imm_j = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12], insn_i[20], insn_i[30:21], 1'b0};
  assign imm_u = {insn_i[31:12], 12'd0};

  // funct3 to ALU operation, shared by OP and OP-IMM
  // bit 30 picks sub and sra; for OP-IMM it only counts on shifts
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == riscv_pkg::OP_REG && insn_i[30]) ?
                          riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
      3'b001:  arith_op = riscv_pkg::ALU_SLL;
      3'b010:  arith_op = riscv_pkg::ALU_SLT;
      3'b011:  arith_op = riscv_pkg::ALU_SLTU;
      3'b100:  arith_op = riscv_pkg::ALU_XOR;
      3'b101:  arith_op = insn_i[30] ? riscv_pkg::ALU_SRA : riscv_pkg::ALU_SRL;
      3'b110:  arith_op = riscv_pkg::ALU_OR;
      default: arith_op = riscv_pkg::ALU_AND;
    endcase
  end

  // legal funct7 values: 0x00 everywhere, 0x20 only for sub and sra/srai
  always_comb begin
    if (opcode == riscv_pkg::OP_IMM && funct3 != 3'b001 && funct3 != 3'b101) begin
      funct7_ok = 1'b1;
    end else if (funct7 == 7'b0000000) begin
      funct7_ok = 1'b1;
    end else if (funct7 == 7'b0100000) begin
      funct7_ok = (funct3 == 3'b101) || (opcode == riscv_pkg::OP_REG && funct3 == 3'b000);
    end else begin
      funct7_ok = 1'b0;
    end
  end

  always_comb begin
    imm_o          = imm_i;
    alu_op_o       = riscv_pkg::ALU_ADD;
    alu_src_imm_o  = 1'b1;
    br_cond_o      = riscv_pkg::BR_NONE;
    jal_o          = 1'b0;
    jalr_o         = 1'b0;
    auipc_o        = 1'b0;
    load_o         = 1'b0;
    store_o        = 1'b0;
    mem_size_o     = riscv_pkg::mem_size_e'(funct3[1:0]);
    mem_unsigned_o = funct3[2];
    reg_write_o    = 1'b0;
    halt_req_o     = 1'b0;
    illegal_o      = 1'b0;

    case (opcode)
      riscv_pkg::OP_LUI: begin
        imm_o       = imm_u;
        alu_op_o    = riscv_pkg::ALU_PASS_B;
        reg_write_o = 1'b1;
      end
      riscv_pkg::OP_AUIPC: begin
        imm_o       = imm_u;
        auipc_o     = 1'b1;
        reg_write_o = 1'b1;
      end
      riscv_pkg::OP_JAL: begin
        imm_o       = imm_j;
        jal_o       = 1'b1;
        reg_write_o = 1'b1;
      end
      riscv_pkg::OP_JALR: begin
        jalr_o      = (funct3 == 3'b000);
        reg_write_o = (funct3 == 3'b000);
        illegal_o   = (funct3 != 3'b000);
      end
      riscv_pkg::OP_BRANCH: begin
        imm_o         = imm_b;
        alu_src_imm_o = 1'b0;
        case (funct3)
          3'b000:  br_cond_o = riscv_pkg::BR_EQ;
          3'b001:  br_cond_o = riscv_pkg::BR_NE;
          3'b100:  br_cond_o = riscv_pkg::BR_LT;
          3'b101:  br_cond_o = riscv_pkg::BR_GE;
          3'b110:  br_cond_o = riscv_pkg::BR_LTU;
          3'b111:  br_cond_o = riscv_pkg::BR_GEU;
          default: illegal_o = 1'b1;
        endcase
      end
      riscv_pkg::OP_LOAD: begin
        // lb lh lw lbu lhu only
        if (funct3 == 3'b011 || funct3 == 3'b110 || funct3 == 3'b111) begin
          illegal_o = 1'b1;
        end else begin
          load_o      = 1'b1;
          reg_write_o = 1'b1;
        end
      end
      riscv_pkg::OP_STORE: begin
        imm_o     = imm_s;
        store_o   = (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b010);
        illegal_o = !(funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b010);
      end
      riscv_pkg::OP_IMM, riscv_pkg::OP_REG: begin
        alu_op_o      = arith_op;
        alu_src_imm_o = (opcode == riscv_pkg::OP_IMM);
        reg_write_o   = funct7_ok;
        illegal_o     = !funct7_ok;
      end
      riscv_pkg::OP_MISC_MEM: begin
        // fence completes in order anyway, nothing to do
      end
      riscv_pkg::OP_SYSTEM: begin
        // ecall is the only supported system instruction
        halt_req_o = (insn_i[31:7] == 25'd0);
        illegal_o  = (insn_i[31:7] != 25'd0);
      end
      default: begin
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu (
  input  riscv_pkg::word_t    a_i,
  input  riscv_pkg::word_t    b_i,
  input  riscv_pkg::alu_op_e  op_i,
  input  riscv_pkg::br_cond_e cond_i,
  output riscv_pkg::word_t    result_o,
  output logic                taken_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;
  logic       equal;

  assign shamt = b_i[4:0];

  // comparisons shared by slt/sltu and the branches
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;
  assign equal       = (a_i == b_i);

  always_comb begin
    case (op_i)
      riscv_pkg::ALU_ADD:    result_o = a_i + b_i;
      riscv_pkg::ALU_SUB:    result_o = a_i - b_i;
      riscv_pkg::ALU_SLL:    result_o = a_i << shamt;
      riscv_pkg::ALU_SLT:    result_o = {31'd0, lt_signed};
      riscv_pkg::ALU_SLTU:   result_o = {31'd0, lt_unsigned};
      riscv_pkg::ALU_XOR:    result_o = a_i ^ b_i;
      riscv_pkg::ALU_SRL:    result_o = a_i >> shamt;
      riscv_pkg::ALU_SRA:    result_o = riscv_pkg::word_t'($signed(a_i) >>> shamt);
      riscv_pkg::ALU_OR:     result_o = a_i | b_i;
      riscv_pkg::ALU_AND:    result_o = a_i & b_i;
      riscv_pkg::ALU_PASS_B: result_o = b_i;
      default:               result_o = '0;
    endcase
  end

  // branch decision, evaluated alongside the result
  always_comb begin
    case (cond_i)
      riscv_pkg::BR_EQ:  taken_o = equal;
      riscv_pkg::BR_NE:  taken_o = !equal;
      riscv_pkg::BR_LT:  taken_o = lt_signed;
      riscv_pkg::BR_GE:  taken_o = !lt_signed;
      riscv_pkg::BR_LTU: taken_o = lt_unsigned;
      riscv_pkg::BR_GEU: taken_o = !lt_unsigned;
      default:           taken_o = 1'b0;
    endcase
  end

endmodule

// File: load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
  input  riscv_pkg::word_t     addr_i,
  input  riscv_pkg::word_t     store_data_i,
  input  logic                 store_i,
  input  logic                 load_i,
  input  riscv_pkg::mem_size_e size_i,
  input  logic                 unsigned_i,
  output riscv_pkg::word_t     dmem_addr_o,
  output riscv_pkg::word_t     dmem_wdata_o,
  output riscv_pkg::strobe_t   dmem_strb_o,
  input  riscv_pkg::word_t     dmem_rdata_i,
  output riscv_pkg::word_t     load_data_o
);

  logic [1:0]        offset;
  riscv_pkg::word_t  lane_data;
  riscv_pkg::word_t  extended;
  logic              misaligned;

  assign offset      = addr_i[1:0];
  assign dmem_addr_o = {addr_i[31:2], 2'b00};

  // store side
  // the value is copied into every lane, the strobe picks the one written
  always_comb begin
    case (size_i)
      riscv_pkg::MEM_BYTE: begin
        dmem_wdata_o = {4{store_data_i[7:0]}};
        dmem_strb_o  = riscv_pkg::strobe_t'(4'b0001 << offset);
      end
      riscv_pkg::MEM_HALF: begin
        dmem_wdata_o = {2{store_data_i[15:0]}};
        dmem_strb_o  = offset[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        dmem_wdata_o = store_data_i;
        dmem_strb_o  = 4'b1111;
      end
    endcase
    if (!store_i) begin
      dmem_strb_o = '0;
    end
  end

  // load side, move the addressed lane down to bit 0
  assign lane_data = dmem_rdata_i >> {offset, 3'b000};

  always_comb begin
    case (size_i)
      riscv_pkg::MEM_BYTE: begin
        extended = unsigned_i ? {24'd0, lane_data[7:0]} :
                                {{24{lane_data[7]}}, lane_data[7:0]};
      end
      riscv_pkg::MEM_HALF: begin
        extended = unsigned_i ? {16'd0, lane_data[15:0]} :
                                {{16{lane_data[15]}}, lane_data[15:0]};
      end
      default: begin
        extended = dmem_rdata_i;
      end
    endcase
  end

  assign load_data_o = load_i ? extended : '0;

  // halfwords must not straddle lanes 1-2 or cross the word
  assign misaligned = ((size_i == riscv_pkg::MEM_HALF) && offset[0]) ||
                      ((size_i == riscv_pkg::MEM_WORD) && (offset != 2'b00));

  always_comb begin
    if (load_i || store_i) begin
      assert final (!misaligned)
        else $error("misaligned access at %h, size %s", addr_i, size_i.name());
    end
  end

endmodule

// File: rv_core.sv
`timescale 1ns/1ps

module rv_core #(
  parameter riscv_pkg::word_t RESET_PC = '0
) (
  input  logic                clk,
  input  logic                rst,
  output riscv_pkg::word_t    imem_addr_o,
  input  riscv_pkg::word_t    imem_data_i,
  output riscv_pkg::word_t    dmem_addr_o,
  output riscv_pkg::word_t    dmem_wdata_o,
  input  riscv_pkg::word_t    dmem_rdata_i,
  output riscv_pkg::strobe_t  dmem_strb_o,
  output logic                halt_o,
  output logic                illegal_o
);

  riscv_pkg::word_t     pc_q;
  riscv_pkg::word_t     pc_next;
  riscv_pkg::word_t     pc_plus4;
  riscv_pkg::word_t     pc_imm;
  logic                 halt_q;
  logic                 illegal_q;
  logic                 active;
  logic                 stop;

  riscv_pkg::reg_idx_t  rs1_idx;
  riscv_pkg::reg_idx_t  rs2_idx;
  riscv_pkg::reg_idx_t  rd_idx;
  riscv_pkg::word_t     rs1_data;
  riscv_pkg::word_t     rs2_data;
  riscv_pkg::word_t     imm;
  riscv_pkg::word_t     alu_b;
  riscv_pkg::word_t     alu_result;
  riscv_pkg::word_t     load_data;
  riscv_pkg::word_t     wb_data;
  riscv_pkg::alu_op_e   alu_op;
  riscv_pkg::br_cond_e  br_cond;
  riscv_pkg::mem_size_e mem_size;
  logic                 alu_src_imm;
  logic                 jal;
  logic                 jalr;
  logic                 auipc;
  logic                 load;
  logic                 store;
  logic                 mem_unsigned;
  logic                 reg_write;
  logic                 halt_req;
  logic                 illegal;
  logic                 taken;

  assign imem_addr_o = pc_q;
  assign halt_o      = halt_q;
  assign illegal_o   = illegal_q;

  // no side effects while reset is applied or after a halt
  assign active = !rst && !halt_q;
  assign stop   = halt_req || illegal;

  insn_decode insn_decode_inst (
    .insn_i         (imem_data_i),
    .rs1_o          (rs1_idx),
    .rs2_o          (rs2_idx),
    .rd_o           (rd_idx),
    .imm_o          (imm),
    .alu_op_o       (alu_op),
    .alu_src_imm_o  (alu_src_imm),
    .br_cond_o      (br_cond),
    .jal_o          (jal),
    .jalr_o         (jalr),
    .auipc_o        (auipc),
    .load_o         (load),
    .store_o        (store),
    .mem_size_o     (mem_size),
    .mem_unsigned_o (mem_unsigned),
    .reg_write_o    (reg_write),
    .halt_req_o     (halt_req),
    .illegal_o      (illegal)
  );

  reg_file reg_file_inst (
    .clk        (clk),
    .rst        (rst),
    .rs1_i      (rs1_idx),
    .rs2_i      (rs2_idx),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .rd_i       (rd_idx),
    .rd_data_i  (wb_data),
    .we_i       (reg_write && active)
  );

  assign alu_b = alu_src_imm ? imm : rs2_data;

  alu alu_inst (
    .a_i      (rs1_data),
    .b_i      (alu_b),
    .op_i     (alu_op),
    .cond_i   (br_cond),
    .result_o (alu_result),
    .taken_o  (taken)
  );

  // effective address is the ALU sum rs1 + imm
  load_store_unit load_store_unit_inst (
    .addr_i       (alu_result),
    .store_data_i (rs2_data),
    .store_i      (store && active),
    .load_i       (load && active),
    .size_i       (mem_size),
    .unsigned_i   (mem_unsigned),
    .dmem_addr_o  (dmem_addr_o),
    .dmem_wdata_o (dmem_wdata_o),
    .dmem_strb_o  (dmem_strb_o),
    .dmem_rdata_i (dmem_rdata_i),
    .load_data_o  (load_data)
  );

  assign pc_plus4 = pc_q + 32'd4;
  assign pc_imm   = pc_q + imm;

  always_comb begin
    if (load) begin
      wb_data = load_data;
    end else if (jal || jalr) begin
      wb_data = pc_plus4;
    end else if (auipc) begin
      wb_data = pc_imm;
    end else begin
      wb_data = alu_result;
    end
  end

  // ecall and illegal opcodes keep the pc on the halting instruction
  always_comb begin
    if (halt_q || stop) begin
      pc_next = pc_q;
    end else if (jalr) begin
      pc_next = {alu_result[31:1], 1'b0};
    end else if (jal || taken) begin
      pc_next = pc_imm;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q      <= RESET_PC;
      halt_q    <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      pc_q <= pc_next;
      if (!halt_q) begin
        halt_q    <= stop;
        illegal_q <= illegal;
      end
    end
  end

  // catches misaligned jump and branch targets
  pc_aligned_a : assert property (@(posedge clk) disable iff (rst) pc_q[1:0] == 2'b00)
    else $error("pc %h not word-aligned", pc_q);

  pc_held_a : assert property (@(posedge clk) disable iff (rst) halt_q |=> $stable(pc_q))
    else $error("pc moved while halted");

endmodule

// File: tb_memory.sv
`timescale 1ns/1ps

module tb_memory #(
  parameter int DEPTH_WORDS = 256
) (
  input  logic               clk,
  input  riscv_pkg::word_t   imem_addr_i,
  output riscv_pkg::word_t   imem_data_o,
  input  riscv_pkg::word_t   dmem_addr_i,
  input  riscv_pkg::word_t   dmem_wdata_i,
  input  riscv_pkg::strobe_t dmem_strb_i,
  output riscv_pkg::word_t   dmem_rdata_o
);

  localparam int AW = $clog2(DEPTH_WORDS);

  riscv_pkg::word_t mem [DEPTH_WORDS];

  // words the program does not set read back a pattern tied to their address
  initial begin
    for (int i = 0; i < DEPTH_WORDS; i++) begin
      mem[i] = 32'hDEAD0000 ^ (riscv_pkg::word_t'(i) << 2);
    end
    $readmemh("program.hex", mem);
  end

  // both ports answer in the same cycle
  assign imem_data_o  = mem[imem_addr_i[AW+1:2]];
  assign dmem_rdata_o = mem[dmem_addr_i[AW+1:2]];

  always @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (dmem_strb_i[b]) begin
        mem[dmem_addr_i[AW+1:2]][8*b +: 8] <= dmem_wdata_i[8*b +: 8];
      end
    end
  end

endmodule

// File: tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

  localparam int               TIMEOUT_CYCLES = 2000;
  localparam int               HALT_CYCLES    = 20;
  localparam riscv_pkg::word_t ECALL_PC       = 32'h0000_018C;

  logic               clk;
  logic               rst;
  riscv_pkg::word_t   imem_addr_o;
  riscv_pkg::word_t   imem_data_i;
  riscv_pkg::word_t   dmem_addr_o;
  riscv_pkg::word_t   dmem_wdata_o;
  riscv_pkg::word_t   dmem_rdata_i;
  riscv_pkg::strobe_t dmem_strb_o;
  logic               halt_o;
  logic               illegal_o;

  // expected stores in program order
  riscv_pkg::word_t   exp_addr [64];
  riscv_pkg::word_t   exp_data [64];
  riscv_pkg::strobe_t exp_strb [64];
  string              exp_name [64];
  logic [5:0]         table_len;
  logic [5:0]         seen;
  int                 cycles;

  rv_core #(
    .RESET_PC ('0)
  ) rv_core_inst (
    .clk          (clk),
    .rst          (rst),
    .imem_addr_o  (imem_addr_o),
    .imem_data_i  (imem_data_i),
    .dmem_addr_o  (dmem_addr_o),
    .dmem_wdata_o (dmem_wdata_o),
    .dmem_rdata_i (dmem_rdata_i),
    .dmem_strb_o  (dmem_strb_o),
    .halt_o       (halt_o),
    .illegal_o    (illegal_o)
  );

  tb_memory memory_inst (
    .clk          (clk),
    .imem_addr_i  (imem_addr_o),
    .imem_data_o  (imem_data_i),
    .dmem_addr_i  (dmem_addr_o),
    .dmem_wdata_i (dmem_wdata_o),
    .dmem_strb_i  (dmem_strb_o),
    .dmem_rdata_o (dmem_rdata_i)
  );

  initial begin
    clk = 1'b0;
  end

  always #10 clk = ~clk;

  task automatic stop_with_failure();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic add_expected(string name, riscv_pkg::word_t addr, riscv_pkg::word_t data,
                              riscv_pkg::strobe_t strb);
    exp_name[table_len] = name;
    exp_addr[table_len] = addr;
    exp_data[table_len] = data;
    exp_strb[table_len] = strb;
    table_len = table_len + 6'd1;
  endtask

  task automatic build_table();
    table_len = '0;
    // x1 = -7, x2 = 3
    add_expected("add",   32'h200, 32'hFFFF_FFFC, 4'b1111);
    add_expected("sub",   32'h204, 32'hFFFF_FFF6, 4'b1111);
    add_expected("sll",   32'h208, 32'hFFFF_FFC8, 4'b1111);
    add_expected("srl",   32'h20C, 32'h1FFF_FFFF, 4'b1111);
    add_expected("sra",   32'h210, 32'hFFFF_FFFF, 4'b1111);
    add_expected("slt",   32'h214, 32'h0000_0001, 4'b1111);
    add_expected("sltu",  32'h218, 32'h0000_0000, 4'b1111);
    add_expected("xor",   32'h21C, 32'hFFFF_FFFA, 4'b1111);
    add_expected("or",    32'h220, 32'hFFFF_FFFB, 4'b1111);
    add_expected("and",   32'h224, 32'h0000_0001, 4'b1111);
    add_expected("slti",  32'h228, 32'h0000_0001, 4'b1111);
    add_expected("sltiu", 32'h22C, 32'h0000_0001, 4'b1111);
    add_expected("xori",  32'h230, 32'hFFFF_FF09, 4'b1111);
    add_expected("ori",   32'h234, 32'h0000_0703, 4'b1111);
    add_expected("andi",  32'h238, 32'h0000_07F0, 4'b1111);
    add_expected("slli",  32'h23C, 32'hC000_0000, 4'b1111);
    add_expected("srli",  32'h240, 32'h0000_000F, 4'b1111);
    add_expected("srai",  32'h244, 32'hFFFF_FFFC, 4'b1111);
    add_expected("lui",   32'h248, 32'h1234_5000, 4'b1111);
    add_expected("auipc", 32'h24C, 32'h0000_1054, 4'b1111);
    // the marker of a condition is stored only if both of its branches behave
    add_expected("beq",   32'h280, 32'h0000_005A, 4'b1111);
    add_expected("bne",   32'h284, 32'h0000_005A, 4'b1111);
    add_expected("blt",   32'h288, 32'h0000_005A, 4'b1111);
    add_expected("bge",   32'h28C, 32'h0000_005A, 4'b1111);
    add_expected("bltu",  32'h290, 32'h0000_005A, 4'b1111);
    add_expected("bgeu",  32'h294, 32'h0000_005A, 4'b1111);
    add_expected("jal link",  32'h2A0, 32'h0000_0110, 4'b1111);
    add_expected("jalr link", 32'h2A4, 32'h0000_0120, 4'b1111);
    // sub-word data is copied into every lane
    add_expected("sb off 0", 32'h300, 32'h2121_2121, 4'b0001);
    add_expected("sb off 1", 32'h300, 32'hF9F9_F9F9, 4'b0010);
    add_expected("sb off 2", 32'h300, 32'h2121_2121, 4'b0100);
    add_expected("sb off 3", 32'h300, 32'hF9F9_F9F9, 4'b1000);
    add_expected("sh off 0", 32'h304, 32'hFFF9_FFF9, 4'b0011);
    add_expected("sh off 2", 32'h304, 32'h4321_4321, 4'b1100);
    add_expected("lb neg",   32'h2C0, 32'hFFFF_FFF9, 4'b1111);
    add_expected("lbu",      32'h2C4, 32'h0000_00F9, 4'b1111);
    add_expected("lb pos",   32'h2C8, 32'h0000_0021, 4'b1111);
    add_expected("lh neg",   32'h2CC, 32'hFFFF_FFF9, 4'b1111);
    add_expected("lhu",      32'h2D0, 32'h0000_FFF9, 4'b1111);
    add_expected("lh pos",   32'h2D4, 32'h0000_4321, 4'b1111);
    add_expected("lw 0x300", 32'h2D8, 32'hF921_F921, 4'b1111);
    add_expected("lw 0x304", 32'h2DC, 32'h4321_FFF9, 4'b1111);
  endtask

  task automatic report_store_error();
    if (seen >= table_len) begin
      $display("unexpected store to %h with strobe %b after the last expected store",
               dmem_addr_o, dmem_strb_o);
    end else begin
      $display("ERR %s: expected addr %h data %h strb %b, actual addr %h data %h strb %b",
               exp_name[seen], exp_addr[seen], exp_data[seen], exp_strb[seen],
               dmem_addr_o, dmem_wdata_o, dmem_strb_o);
    end
    stop_with_failure();
  endtask

  // a store commits at the rising edge, so the index moves there
  always @(posedge clk) begin
    if (rst) begin
      seen <= '0;
    end else if (dmem_strb_o != 4'b0000) begin
      seen <= seen + 6'd1;
    end
  end

  store_check_a : assert property (@(negedge clk) disable iff (rst)
    (dmem_strb_o != 4'b0000) |-> (seen < table_len && dmem_addr_o == exp_addr[seen] &&
                                  dmem_wdata_o == exp_data[seen] &&
                                  dmem_strb_o == exp_strb[seen]))
    else report_store_error();

  reset_state_a : assert property (@(negedge clk)
    rst |-> (imem_addr_o == '0 && dmem_strb_o == '0 && !halt_o && !illegal_o))
    else begin
      $display("ERR reset: expected pc/strb/halt/illegal 0, actual %h %b %b %b",
               imem_addr_o, dmem_strb_o, halt_o, illegal_o);
      stop_with_failure();
    end

  halt_quiet_a : assert property (@(negedge clk) disable iff (rst)
    halt_o |-> (dmem_strb_o == '0))
    else begin
      $display("ERR halted store: expected strb 0000, actual %b", dmem_strb_o);
      stop_with_failure();
    end

  initial begin
    rst = 1'b1;
    build_table();
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // first cycle out of reset still fetches from the reset address
    @(negedge clk);
    assert (imem_addr_o == '0 && dmem_strb_o == '0 && !halt_o && !illegal_o) else begin
      $display("ERR after reset: expected pc/strb/halt/illegal 0, actual %h %b %b %b",
               imem_addr_o, dmem_strb_o, halt_o, illegal_o);
      stop_with_failure();
    end

    cycles = 0;
    while (!halt_o && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt_o) begin
      $display("core did not halt within %0d cycles", TIMEOUT_CYCLES);
      stop_with_failure();
    end

    assert (!illegal_o) else begin
      $display("ERR ecall: expected illegal_o 0, actual %b", illegal_o);
      stop_with_failure();
    end

    repeat (HALT_CYCLES) begin
      @(negedge clk);
      assert (imem_addr_o == ECALL_PC) else begin
        $display("ERR halt pc: expected %h, actual %h", ECALL_PC, imem_addr_o);
        stop_with_failure();
      end
    end

    if (seen == table_len) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("ERR store count: expected %0d, actual %0d", table_len, seen);
      stop_with_failure();
    end
  end

endmodule

// File: program.hex
// one 32-bit instruction word per line, starting at address 0
// x1 = -7, x2 = 3, ALU results go to x3..x22
FF900093 // addi x1, x0, -7
00300113 // addi x2, x0, 3
002081B3 // add  x3
40208233 // sub  x4
002092B3 // sll  x5
0020D333 // srl  x6
4020D3B3 // sra  x7
0020A433 // slt  x8
0020B4B3 // sltu x9
0020C533 // xor  x10
0020E5B3 // or   x11
0020F633 // and  x12
FFA0A693 // slti  x13, x1, -6
FFF13713 // sltiu x14, x2, -1
0F00C793 // xori  x15, x1, 0x0f0
70016813 // ori   x16, x2, 0x700
7F00F893 // andi  x17, x1, 0x7f0
01E11913 // slli  x18, x2, 30
01C0D993 // srli  x19, x1, 28
4010DA13 // srai  x20, x1, 1
12345AB7 // lui   x21, 0x12345
00001B17 // auipc x22, 0x1 at 0x54
20302023 // sw x3..x22 to 0x200..0x24c
20402223
20502423
20602623
20702823
20802A23
20902C23
20A02E23
22B02023
22C02223
22D02423
22E02623
22F02823
23002A23
23102C23
23202E23
25302023
25402223
25502423
25602623
05A00B93 // addi x23, x0, 0x5a marker
00208463 // beq x1, x2 not taken
29702023 // sw marker 0x280
00108463 // beq x1, x1 taken
3F702823 // wrong path store 0x3f0
00109463 // bne x1, x1 not taken
29702223
00209463 // bne x1, x2 taken
3F702823
00114463 // blt x2, x1 not taken
29702423
0020C463 // blt x1, x2 taken
3F702823
0020D463 // bge x1, x2 not taken
29702623
00115463 // bge x2, x1 taken
3F702823
0020E463 // bltu x1, x2 not taken
29702823
00116463 // bltu x2, x1 taken
3F702823
00117463 // bgeu x2, x1 not taken
29702A23
0020F463 // bgeu x1, x2 taken
3F702823
00800C6F // jal x24, +8 at 0x10c
3F702823
2B802023 // sw x24, 0x2a0
12400C93 // addi x25, x0, 0x124
001C8D67 // jalr x26, 1(x25) at 0x11c
3F702823
2BA02223 // sw x26, 0x2a4
87654DB7 // lui  x27, 0x87654
321D8D93 // addi x27, x27, 0x321
31B00023 // sb x27, 0x300
301000A3 // sb x1, 0x301
31B00123 // sb x27, 0x302
301001A3 // sb x1, 0x303
30101223 // sh x1, 0x304
31B01323 // sh x27, 0x306
30100E03 // lb  x28, 0x301
2DC02023
30304E03 // lbu x28, 0x303
2DC02223
30200E03 // lb  x28, 0x302
2DC02423
30401E03 // lh  x28, 0x304
2DC02623
30405E03 // lhu x28, 0x304
2DC02823
30601E03 // lh  x28, 0x306
2DC02A23
30002E03 // lw  x28, 0x300
2DC02C23
30402E03 // lw  x28, 0x304
2DC02E23
0FF0000F // fence
00000073 // ecall at 0x18c

// File: flist.f
riscv_pkg.sv
reg_file.sv
insn_decode.sv
alu.sv
load_store_unit.sv
rv_core.sv
tb_memory.sv
tb_rv_core.sv

// File: run.sh
#!/usr/bin/env bash
# builds and runs the testbench; the exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --Wno-fatal --top-module tb_rv_core \
  -f flist.f -o tb_rv_core &&
./obj_dir/tb_rv_core || { echo "simulation failed"; exit 1; }
